//--- hw/wrr_pkg.sv
package wrr_pkg;

    // register map allows eight clients at most
    localparam int MAX_CLIENTS = 8;

    // weight field width, weights 1..7
    localparam int WEIGHT_W = 3;

    typedef logic [WEIGHT_W-1:0] weight_t;

    // credit needs one bit more than the weight so weight plus one fits
    typedef logic [WEIGHT_W:0] credit_t;

    // wrapping grant counter
    typedef logic [15:0] gnt_cnt_t;

    // wishbone word address and data
    typedef logic [4:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;

    // weight of client i at ADR_WEIGHT_BASE + i
    localparam wb_adr_t ADR_WEIGHT_BASE = 5'd0;

    // client enable mask, one bit per client
    localparam wb_adr_t ADR_ENABLE = 5'd8;

    // grant counter of client i at ADR_COUNT_BASE + i
    localparam wb_adr_t ADR_COUNT_BASE = 5'd16;

endpackage

//--- hw/rrb_arb.sv
`timescale 1ns/10ps

module rrb_arb #(
    parameter int CLIENTS = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [CLIENTS-1:0] req,
    output logic [CLIENTS-1:0] grant
);

    localparam int PTR_W = $clog2(CLIENTS);

    // client with the highest priority this cycle
    logic [PTR_W-1:0] ptr;
    // index of the winner, only meaningful when grant is nonzero
    logic [PTR_W-1:0] win;

    // search upward from ptr and wrap around
    // first requester found wins, later ones are skipped
    always_comb begin
        int idx;
        grant = '0;
        win   = ptr;
        for (int off = 0; off < CLIENTS; off++) begin
            idx = (int'(ptr) + off) % CLIENTS;
            if (req[idx] && (grant == '0)) begin
                grant[idx] = 1'b1;
                win        = PTR_W'(idx);
            end
        end
    end

    // pointer moves past the winner
    // no grant means the pointer stays put
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (|grant) begin
            if (win == PTR_W'(CLIENTS - 1)) begin
                // wrap back to client 0
                ptr <= '0;
            end else begin
                ptr <= win + 1'b1;
            end
        end
    end

endmodule

//--- hw/weighted_round_robin.sv
`timescale 1ns/10ps

module weighted_round_robin #(
    parameter int CLIENTS = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  wrr_pkg::weight_t [CLIENTS-1:0]        weights,
    input  logic             [CLIENTS-1:0]        req,
    output logic             [CLIENTS-1:0]        grant
);

    // grants taken by each client in the current round
    wrr_pkg::credit_t [CLIENTS-1:0] crd_cnt;
    // count after one more grant
    wrr_pkg::credit_t [CLIENTS-1:0] crd_inc;

    logic [CLIENTS-1:0] has_crd;
    // requests left after credit masking, fed to the plain arbiter
    logic [CLIENTS-1:0] arb_req;
    // round over, every requester has used up its weight
    logic refill;

    // no active requester has credit left, so a new round starts now
    // also true when req is all zero, which just keeps counters at 0
    assign refill = ((req & has_crd) == '0);

    for (genvar i = 0; i < CLIENTS; i++) begin : g_client

        assign crd_inc[i] = crd_cnt[i] + 1'b1;

        // weight zero-extended to the credit width before compare
        assign has_crd[i] = (crd_inc[i] <= wrr_pkg::credit_t'(weights[i]));

        // on refill every requester is eligible again
        assign arb_req[i] = req[i] & (has_crd[i] | refill);

        // counter moves only on its own grant or on a refill
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                crd_cnt[i] <= '0;
            end else if (refill) begin
                // the grant in the refill cycle already counts for the new round
                crd_cnt[i] <= grant[i] ? wrr_pkg::credit_t'(1) : '0;
            end else if (grant[i]) begin
                crd_cnt[i] <= crd_inc[i];
            end
        end

    end

    // plain round robin picks one of the eligible clients
    rrb_arb #(
        .CLIENTS (CLIENTS)
    ) i_rrb_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (arb_req),
        .grant (grant)
    );

endmodule

//--- hw/wb_weight_regs.sv
`timescale 1ns/10ps

module wb_weight_regs #(
    parameter int CLIENTS = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  wrr_pkg::wb_adr_t               wb_adr,
    input  wrr_pkg::wb_dat_t               wb_dat_w,
    output wrr_pkg::wb_dat_t               wb_dat_r,
    output logic                           wb_ack,
    input  logic             [CLIENTS-1:0] grant,
    output wrr_pkg::weight_t [CLIENTS-1:0] weights,
    output logic             [CLIENTS-1:0] req_en
);

    // per-client grant counters, wrap at 16 bits
    wrr_pkg::gnt_cnt_t [CLIENTS-1:0] gnt_cnt;

    // new transfer seen, ack not yet given
    logic access;
    logic wr;

    // address decode
    logic [CLIENTS-1:0] w_hit;
    logic [CLIENTS-1:0] c_hit;
    logic               en_hit;

    wrr_pkg::wb_dat_t rd_data;

    assign access = wb_cyc & wb_stb & ~wb_ack;
    assign wr     = access & wb_we;
    assign en_hit = (wb_adr == wrr_pkg::ADR_ENABLE);

    // one ack cycle per transfer, so a transfer takes two cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    for (genvar i = 0; i < CLIENTS; i++) begin : g_reg
        assign w_hit[i] = (wb_adr == wrr_pkg::ADR_WEIGHT_BASE + wrr_pkg::wb_adr_t'(i));
        assign c_hit[i] = (wb_adr == wrr_pkg::ADR_COUNT_BASE + wrr_pkg::wb_adr_t'(i));

        // weight 0 would starve the client, store it as 1
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                weights[i] <= wrr_pkg::weight_t'(1);
            end else if (wr && w_hit[i]) begin
                if (wb_dat_w[wrr_pkg::WEIGHT_W-1:0] == '0) begin
                    weights[i] <= wrr_pkg::weight_t'(1);
                end else begin
                    weights[i] <= wb_dat_w[wrr_pkg::WEIGHT_W-1:0];
                end
            end
        end

        // write clear beats a grant on the same edge
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                gnt_cnt[i] <= '0;
            end else if (wr && c_hit[i]) begin
                gnt_cnt[i] <= '0;
            end else if (grant[i]) begin
                gnt_cnt[i] <= gnt_cnt[i] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_en <= '1;
        end else if (wr && en_hit) begin
            req_en <= wb_dat_w[CLIENTS-1:0];
        end
    end

    // read mux, unmapped and out-of-range addresses give 0
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < CLIENTS; i++) begin
            if (w_hit[i]) begin
                rd_data = wrr_pkg::wb_dat_t'(weights[i]);
            end
            if (c_hit[i]) begin
                rd_data = wrr_pkg::wb_dat_t'(gnt_cnt[i]);
            end
        end
        if (en_hit) begin
            rd_data = wrr_pkg::wb_dat_t'(req_en);
        end
    end

    // sampled with the request, held while ack is high
    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

//--- hw/wrr_arbiter_top.sv
`timescale 1ns/10ps

module wrr_arbiter_top #(
    parameter int CLIENTS = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  wrr_pkg::wb_adr_t         wb_adr,
    input  wrr_pkg::wb_dat_t         wb_dat_w,
    output wrr_pkg::wb_dat_t         wb_dat_r,
    output logic                     wb_ack,
    input  logic       [CLIENTS-1:0] req,
    output logic       [CLIENTS-1:0] grant
);

    // register map has room for MAX_CLIENTS weights and counters
    if (CLIENTS < 2 || CLIENTS > wrr_pkg::MAX_CLIENTS) begin : g_bad_clients
        $error("CLIENTS out of range");
    end

    wrr_pkg::weight_t [CLIENTS-1:0] weights;
    logic             [CLIENTS-1:0] req_en;
    // requests after the enable mask
    logic             [CLIENTS-1:0] req_gated;

    assign req_gated = req & req_en;

    wb_weight_regs #(
        .CLIENTS (CLIENTS)
    ) i_wb_weight_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .grant    (grant),
        .weights  (weights),
        .req_en   (req_en)
    );

    weighted_round_robin #(
        .CLIENTS (CLIENTS)
    ) i_weighted_round_robin (
        .clk     (clk),
        .rst_n   (rst_n),
        .weights (weights),
        .req     (req_gated),
        .grant   (grant)
    );

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen #(
    parameter int HALF_NS    = 4,
    parameter int RST_CYCLES = 3
) (
    input  logic restart,
    output logic clk,
    output logic rst_n
);

    // 8 ns period with the default half period
    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    // power-on reset, then the same again on every restart request
    initial begin
        rst_n = 1'b0;
        forever begin
            repeat (RST_CYCLES) @(posedge clk);
            // release on a falling edge, away from the active edge
            @(negedge clk);
            rst_n = 1'b1;
            @(posedge restart);
            rst_n = 1'b0;
        end
    end

endmodule

//--- tb/wrr_arbiter_checker.sv
`timescale 1ns/10ps

module wrr_arbiter_checker #(
    parameter int CLIENTS = 8
) (
    input logic               clk,
    input logic               rst_n,
    input logic [CLIENTS-1:0] req,
    input logic [CLIENTS-1:0] grant
);

    // at most one winner per cycle
    a_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
        else $error("grant is not one-hot or zero: %b", grant);

    // only a client that asks may win
    a_subset: assert property (@(posedge clk) disable iff (!rst_n) (grant & ~req) == '0)
        else $error("grant %b outside of req %b", grant, req);

    // refill keeps the arbiter busy, no idle cycle while someone asks
    a_busy: assert property (@(posedge clk) disable iff (!rst_n) (|req) |-> (|grant))
        else $error("req %b present but no grant", req);

endmodule

// req here is already gated by the enable mask in the top level
bind weighted_round_robin wrr_arbiter_checker #(
    .CLIENTS (CLIENTS)
) i_wrr_arbiter_checker (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .grant (grant)
);

//--- tb/tb_wrr_arbiter.sv
`timescale 1ns/10ps

module tb_wrr_arbiter;

    localparam int CLIENTS  = 8;
    localparam int NUM_ROWS = 5;

    logic               clk;
    logic               rst_n;
    logic               restart;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    wrr_pkg::wb_adr_t   wb_adr;
    wrr_pkg::wb_dat_t   wb_dat_w;
    wrr_pkg::wb_dat_t   wb_dat_r;
    logic               wb_ack;
    logic [CLIENTS-1:0] req;
    logic [CLIENTS-1:0] grant;

    // stimulus table with one row per test
    // weights hold one octal digit per client and client 0 sits in the lowest digit
    string       row_name [NUM_ROWS];
    logic [23:0] row_w    [NUM_ROWS];
    logic [7:0]  row_mask [NUM_ROWS];
    logic [7:0]  row_req  [NUM_ROWS];
    int          row_k    [NUM_ROWS];

    int value_errs;
    int proto_errs;
    int cycle_cnt = 0;
    int cycle_limit;
    int seed;

    tb_clkgen #(.HALF_NS(4), .RST_CYCLES(3)) i_tb_clkgen (
        .restart (restart),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    wrr_arbiter_top #(.CLIENTS(CLIENTS)) i_wrr_arbiter_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .req      (req),
        .grant    (grant)
    );

    task automatic set_row(input int r, input string name, input logic [23:0] w,
                           input logic [7:0] mask, input logic [7:0] rq, input int k);
        row_name[r] = name;
        row_w[r]    = w;
        row_mask[r] = mask;
        row_req[r]  = rq;
        row_k[r]    = k;
    endtask

    function automatic int weight_of(input int r, input int i);
        return int'(row_w[r][3*i +: 3]);
    endfunction

    // length of one round over the enabled requesting clients
    function automatic int round_len(input int r);
        int sum;
        sum = 0;
        for (int i = 0; i < CLIENTS; i++) begin
            if (row_req[r][i] && row_mask[r][i]) begin
                sum += weight_of(r, i);
            end
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input int exp, input int act);
        assert (exp == act) else begin
            value_errs++;
            $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // one classic transfer that starts and ends on a falling edge
    task automatic bus_xfer(input logic we, input wrr_pkg::wb_adr_t adr,
                            input wrr_pkg::wb_dat_t wdata, output wrr_pkg::wb_dat_t rdata);
        int waits;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        waits    = 1;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
            waits++;
        end
        // ack is due on the first edge after the request
        assert (waits == 1) else begin
            proto_errs++;
            $display("ack for address %0d came after %0d cycles instead of 1", adr, waits);
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
        assert (!wb_ack) else begin
            proto_errs++;
            $display("ack for address %0d stayed high for a second cycle", adr);
        end
    endtask

    task automatic bus_write(input wrr_pkg::wb_adr_t adr, input wrr_pkg::wb_dat_t data);
        wrr_pkg::wb_dat_t unused;
        bus_xfer(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input wrr_pkg::wb_adr_t adr, output wrr_pkg::wb_dat_t data);
        bus_xfer(1'b0, adr, '0, data);
    endtask

    // returns on the falling edge where reset goes away
    task automatic apply_reset();
        restart = 1'b1;
        @(negedge clk);
        restart = 1'b0;
        wait (rst_n === 1'b1);
    endtask

    task automatic run_row(input int r);
        wrr_pkg::wb_dat_t rdata;
        logic [7:0]       active;
        int               hold;
        active = row_req[r] & row_mask[r];
        hold   = row_k[r] * round_len(r);
        apply_reset();
        for (int i = 0; i < CLIENTS; i++) begin
            bus_write(wrr_pkg::ADR_WEIGHT_BASE + wrr_pkg::wb_adr_t'(i),
                      wrr_pkg::wb_dat_t'(row_w[r][3*i +: 3]));
        end
        bus_write(wrr_pkg::ADR_ENABLE, wrr_pkg::wb_dat_t'(row_mask[r]));
        // k full rounds of W cycles each
        req = row_req[r];
        for (int n = 0; n < hold; n++) begin
            @(negedge clk);
            // a lone requester wins every cycle
            if ($countones(active) == 1) begin
                check_value($sformatf("%s grant", row_name[r]), int'(active), int'(grant));
            end
        end
        req = '0;
        for (int i = 0; i < CLIENTS; i++) begin
            bus_read(wrr_pkg::ADR_COUNT_BASE + wrr_pkg::wb_adr_t'(i), rdata);
            check_value($sformatf("%s cnt%0d", row_name[r], i),
                        active[i] ? row_k[r] * weight_of(r, i) : 0, int'(rdata));
        end
    endtask

    task automatic readback_test();
        wrr_pkg::wb_dat_t rdata;
        logic [31:0]      rnd;
        logic [2:0]       wv [CLIENTS];
        logic [7:0]       mask;
        int               total;
        apply_reset();
        for (int i = 0; i < CLIENTS; i++) begin
            rnd   = $random(seed);
            wv[i] = rnd[2:0];
            bus_write(wrr_pkg::ADR_WEIGHT_BASE + wrr_pkg::wb_adr_t'(i), wrr_pkg::wb_dat_t'(wv[i]));
        end
        rnd  = $random(seed);
        mask = rnd[7:0];
        bus_write(wrr_pkg::ADR_ENABLE, wrr_pkg::wb_dat_t'(mask));
        // weight 0 is stored as 1
        for (int i = 0; i < CLIENTS; i++) begin
            bus_read(wrr_pkg::ADR_WEIGHT_BASE + wrr_pkg::wb_adr_t'(i), rdata);
            check_value($sformatf("readback weight%0d", i),
                        (wv[i] == 3'd0) ? 1 : int'(wv[i]), int'(rdata));
        end
        bus_read(wrr_pkg::ADR_ENABLE, rdata);
        check_value("readback mask", int'(mask), int'(rdata));
        // holes between the enable register and the counters, and above them
        for (int a = 9; a < 32; a++) begin
            if (a < 16 || a >= 24) begin
                bus_read(wrr_pkg::wb_adr_t'(a), rdata);
                check_value($sformatf("unmapped %0d", a), 0, int'(rdata));
            end
        end
        // one grant per cycle, so the counters add up to the burst length
        bus_write(wrr_pkg::ADR_ENABLE, 32'hff);
        req = '1;
        repeat (12) @(negedge clk);
        req   = '0;
        total = 0;
        for (int i = 0; i < CLIENTS; i++) begin
            bus_read(wrr_pkg::ADR_COUNT_BASE + wrr_pkg::wb_adr_t'(i), rdata);
            total += int'(rdata);
        end
        check_value("counter total", 12, total);
        // client 2 won at least once in the burst
        // any write data clears the counter
        bus_write(wrr_pkg::ADR_COUNT_BASE + 5'd2, 32'h1234);
        bus_read(wrr_pkg::ADR_COUNT_BASE + 5'd2, rdata);
        check_value("counter clear", 0, int'(rdata));
    endtask

    // watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        req        = '0;
        restart    = 1'b0;
        value_errs = 0;
        proto_errs = 0;
        seed       = 32'h715f;
        set_row(0, "equal",     24'o11111111, 8'hff,        8'hff,        3);
        set_row(1, "mixed",     24'o76543211, 8'hff,        8'b1010_1101, 2);
        set_row(2, "mask",      24'o32132132, 8'b0110_0110, 8'hff,        3);
        set_row(3, "single_w5", 24'o11115111, 8'hff,        8'h08,        2);
        set_row(4, "single_w7", 24'o71111111, 8'hff,        8'h80,        1);
        // about 40 cycles of reset and bus traffic per row plus the readback test
        cycle_limit = 200;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += 2 * (row_k[r] * round_len(r) + 40);
        end
        wait (rst_n === 1'b1);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        readback_test();
        $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/wrr_pkg.sv
hw/rrb_arb.sv
hw/weighted_round_robin.sv
hw/wb_weight_regs.sv
hw/wrr_arbiter_top.sv
tb/tb_clkgen.sv
tb/wrr_arbiter_checker.sv
tb/tb_wrr_arbiter.sv

//--- Makefile
TOOL    = verilator
FLAGS   = --binary --timing --assert
TOP     = tb_wrr_arbiter
FLIST   = vlog.f
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
